// File: common/llc_geom_pkg.sv
// Cache geometry constants for the LLC tag store, used as parameter defaults by the top level
package llc_geom_pkg;

  // Associativity
  // Fixed, the tree pseudo-LRU is built for exactly four leaves
  localparam int unsigned NUM_WAYS = 4;

  // Default number of sets per way
  // The top level passes its own value down to every module that indexes a set
  localparam int unsigned DEF_NUM_LINES = 16;

  // Default tag width in bits
  // Excludes the valid and dirty flags stored next to the tag
  localparam int unsigned DEF_TAG_WIDTH = 12;

endpackage

// File: common/llc_op_pkg.sv
// Request mode codes and tag word layout shared by the tag store control and datapath
package llc_op_pkg;

  // Width of the request mode field
  localparam int unsigned MODE_W = 2;

  // Way-targeted eviction, the named word is cleared afterwards
  localparam logic [MODE_W-1:0] MODE_FLUSH = 2'b10;
  // Tag compare over the enabled ways, with a write-back when needed
  localparam logic [MODE_W-1:0] MODE_LOOKUP = 2'b11;
  // Other codes are accepted and dropped without a response

  // Tag word layout
  // The tag sits in the low bits, the two flags sit above it
  // Flag positions are counted from the first bit above the tag
  localparam int unsigned TW_DIT_BIT = 0;
  localparam int unsigned TW_VAL_BIT = 1;

  // Number of flag bits stored on top of each tag
  localparam int unsigned TW_FLAG_BITS = 2;

endpackage

// File: logic/llc_tag_ram.sv
// Four-way tag memory with registered read, used by the tag store for lookups and write-backs
`timescale 1ns/1ns

module llc_tag_ram import llc_geom_pkg::*, llc_op_pkg::*; #(
  parameter int unsigned NumLines = DEF_NUM_LINES,
  parameter int unsigned TagWidth = DEF_TAG_WIDTH,
  localparam int unsigned IdxWidth = $clog2(NumLines),
  localparam int unsigned WordWidth = TagWidth + TW_FLAG_BITS
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               ram_req_i,
  // Per-way write mask, all zero means a read of every way
  input  logic [NUM_WAYS-1:0]                ram_we_i,
  input  logic [IdxWidth-1:0]                index_i,
  input  logic [WordWidth-1:0]               wword_i,
  output logic [NUM_WAYS-1:0][WordWidth-1:0] rword_o,
  output logic                               rvalid_o
);

  logic [WordWidth-1:0]               mem_q [NUM_WAYS][NumLines];
  // Set once a word has been written since reset
  logic [NumLines-1:0][NUM_WAYS-1:0]  written_q;
  logic [NUM_WAYS-1:0][WordWidth-1:0] rdata_q;
  logic [NUM_WAYS-1:0]                rflag_q;
  logic                               rd_en;

  assign rd_en = ram_req_i & ~(|ram_we_i);

  always_ff @(posedge clk_i) begin
    if (ram_req_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (ram_we_i[w]) begin
          mem_q[w][index_i] <= wword_i;
        end
      end
    end
    // Read data holds until the next read
    if (rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        rdata_q[w] <= mem_q[w][index_i];
      end
      rflag_q <= written_q[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      written_q <= '0;
      rvalid_o  <= 1'b0;
    end else begin
      if (ram_req_i) begin
        written_q[index_i] <= written_q[index_i] | ram_we_i;
      end
      rvalid_o <= rd_en;
    end
  end

  // Never-written words read back as all zeros, so invalid
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rword_o[w] = rflag_q[w] ? rdata_q[w] : '0;
    end
  end

endmodule

// File: logic/llc_tag_match.sv
// Per-way tag compare and stored word select for the tag store controller
`timescale 1ns/1ns

module llc_tag_match import llc_geom_pkg::*, llc_op_pkg::*; #(
  parameter int unsigned TagWidth = DEF_TAG_WIDTH,
  localparam int unsigned WordWidth = TagWidth + TW_FLAG_BITS
) (
  // Words read from all ways of one set
  input  logic [NUM_WAYS-1:0][WordWidth-1:0] rword_i,
  input  logic [TagWidth-1:0]                cmp_tag_i,
  // Ways taking part in the compare
  input  logic [NUM_WAYS-1:0]                cmp_way_i,
  // One-hot way whose stored word is reported
  input  logic [NUM_WAYS-1:0]                sel_way_i,
  output logic [NUM_WAYS-1:0]                hit_o,
  output logic [NUM_WAYS-1:0]                tw_val_o,
  output logic [NUM_WAYS-1:0]                tw_dit_o,
  output logic [TagWidth-1:0]                sel_tag_o,
  output logic                               sel_val_o,
  output logic                               sel_dit_o
);

  logic [WordWidth-1:0] sel_word;
  logic [NUM_WAYS-1:0]  tag_equ;

  always_comb begin
    sel_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      tw_val_o[w] = rword_i[w][TagWidth + TW_VAL_BIT];
      tw_dit_o[w] = rword_i[w][TagWidth + TW_DIT_BIT];
      tag_equ[w]  = (rword_i[w][TagWidth-1:0] == cmp_tag_i);
      // Stale tags in invalid or disabled ways never hit
      hit_o[w]    = cmp_way_i[w] & tw_val_o[w] & tag_equ[w];
      // AND-OR mux, select is one-hot
      sel_word    = sel_word | (rword_i[w] & {WordWidth{sel_way_i[w]}});
    end
  end

  assign sel_tag_o = sel_word[TagWidth-1:0];
  assign sel_val_o = sel_word[TagWidth + TW_VAL_BIT];
  assign sel_dit_o = sel_word[TagWidth + TW_DIT_BIT];

endmodule

// File: logic/llc_plru.sv
// Tree pseudo-LRU per set, gives a lock-aware victim for lookup misses in the tag store
`timescale 1ns/1ns

module llc_plru import llc_geom_pkg::*; #(
  parameter int unsigned NumLines = DEF_NUM_LINES,
  localparam int unsigned IdxWidth = $clog2(NumLines)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Marks way_i of set index_i as most recently used
  input  logic                update_i,
  input  logic [IdxWidth-1:0] index_i,
  input  logic [NUM_WAYS-1:0] way_i,
  input  logic [NUM_WAYS-1:0] lock_i,
  input  logic [NUM_WAYS-1:0] enable_i,
  output logic [NUM_WAYS-1:0] victim_o
);

  // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
  logic [NumLines-1:0][2:0] tree_q;
  logic [2:0]               cur_bits;
  logic [1:0]               tree_way;
  logic [NUM_WAYS-1:0]      tree_oh;
  logic [NUM_WAYS-1:0]      usable;

  assign cur_bits = tree_q[index_i];
  // Root set means upper pair, pair bit set means the higher way
  assign tree_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};
  assign tree_oh  = NUM_WAYS'(1) << tree_way;
  assign usable   = enable_i & ~lock_i;
  // Fall back to the lowest usable way when the tree points at a blocked one
  assign victim_o = (|(tree_oh & usable)) ? tree_oh : (usable & (~usable + 1'b1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tree_q <= '0;
    end else if (update_i) begin
      // Point every bit on the path away from the accessed way
      if (|way_i[1:0]) begin
        tree_q[index_i][0] <= 1'b1;
        tree_q[index_i][1] <= way_i[0];
      end else if (|way_i[3:2]) begin
        tree_q[index_i][0] <= 1'b0;
        tree_q[index_i][2] <= way_i[2];
      end
    end
  end

endmodule

// File: logic/llc_resp_reg.sv
// One-entry response register between the tag compare and the response port of the tag store
`timescale 1ns/1ns

module llc_resp_reg import llc_geom_pkg::*; #(
  parameter int unsigned TagWidth = DEF_TAG_WIDTH
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // From the controller
  input  logic                valid_i,
  output logic                ready_o,
  input  logic [NUM_WAYS-1:0] way_i,
  input  logic                hit_i,
  input  logic                evict_i,
  input  logic [TagWidth-1:0] evict_tag_i,
  // To the outside
  output logic                valid_o,
  input  logic                ready_i,
  output logic [NUM_WAYS-1:0] way_o,
  output logic                hit_o,
  output logic                evict_o,
  output logic [TagWidth-1:0] evict_tag_o
);

  logic full_q;
  logic load;

  // Free when empty or when the held entry leaves on this edge
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;
  assign valid_o = full_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Data only changes on a load, so it stays put under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      way_o       <= way_i;
      hit_o       <= hit_i;
      evict_o     <= evict_i;
      evict_tag_o <= evict_tag_i;
    end
  end

endmodule

// File: tag_store/llc_tag_ctrl.sv
// Tag store controller, accepts one request, reads the set, builds the response and writes back
`timescale 1ns/1ns

module llc_tag_ctrl import llc_geom_pkg::*, llc_op_pkg::*; #(
  parameter int unsigned NumLines = DEF_NUM_LINES,
  parameter int unsigned TagWidth = DEF_TAG_WIDTH,
  localparam int unsigned IdxWidth = $clog2(NumLines),
  localparam int unsigned WordWidth = TagWidth + TW_FLAG_BITS
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [MODE_W-1:0]    req_mode_i,
  input  logic [IdxWidth-1:0]  req_index_i,
  input  logic [TagWidth-1:0]  req_tag_i,
  input  logic                 req_dirty_i,
  input  logic [NUM_WAYS-1:0]  req_way_i,
  // Tag RAM
  output logic                 ram_req_o,
  output logic [NUM_WAYS-1:0]  ram_we_o,
  output logic [IdxWidth-1:0]  ram_index_o,
  output logic [WordWidth-1:0] ram_wword_o,
  input  logic                 ram_rvalid_i,
  // Matcher
  output logic [TagWidth-1:0]  cmp_tag_o,
  output logic [NUM_WAYS-1:0]  cmp_way_o,
  output logic [NUM_WAYS-1:0]  sel_way_o,
  input  logic [NUM_WAYS-1:0]  hit_i,
  input  logic [NUM_WAYS-1:0]  tw_val_i,
  input  logic [NUM_WAYS-1:0]  tw_dit_i,
  input  logic [TagWidth-1:0]  sel_tag_i,
  input  logic                 sel_val_i,
  input  logic                 sel_dit_i,
  // PLRU
  output logic                 plru_update_o,
  output logic [IdxWidth-1:0]  plru_index_o,
  output logic [NUM_WAYS-1:0]  plru_way_o,
  input  logic [NUM_WAYS-1:0]  victim_i,
  // Response register
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output logic [NUM_WAYS-1:0]  rsp_way_o,
  output logic                 rsp_hit_o,
  output logic                 rsp_evict_o,
  output logic [TagWidth-1:0]  rsp_evict_tag_o
);

  // Control state
  logic                 busy_q;
  logic                 rd_pend_q;
  logic                 rvalid_q;
  // Accepted request
  logic [MODE_W-1:0]    mode_q;
  logic [IdxWidth-1:0]  index_q;
  logic [TagWidth-1:0]  tag_q;
  logic                 dirty_q;
  logic [NUM_WAYS-1:0]  way_q;

  logic                 accept;
  logic                 req_known;
  logic                 is_lookup;
  logic                 push;
  logic                 any_hit;
  logic [NUM_WAYS-1:0]  free_ways;
  logic [NUM_WAYS-1:0]  miss_way;
  logic                 wb_en;
  logic [NUM_WAYS-1:0]  wb_mask;

  // Only taken while idle, unknown modes are swallowed here
  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & ~busy_q;
  assign req_known   = (req_mode_i == MODE_LOOKUP) || (req_mode_i == MODE_FLUSH);
  assign is_lookup   = (mode_q == MODE_LOOKUP);

  // Result is ready once the read came back, also after waiting on a full register
  assign rsp_valid_o = busy_q & (ram_rvalid_i | rvalid_q);
  assign push        = rsp_valid_o & rsp_ready_i;

  assign cmp_tag_o = tag_q;
  assign cmp_way_o = way_q;
  assign any_hit   = |hit_i;

  // Prefer an empty enabled way, lowest index first, before asking the PLRU
  assign free_ways = way_q & ~tw_val_i;
  assign miss_way  = (|free_ways) ? (free_ways & (~free_ways + 1'b1)) : victim_i;

  // Response and write-back word per mode
  always_comb begin
    sel_way_o       = way_q;
    rsp_way_o       = way_q;
    rsp_hit_o       = 1'b0;
    rsp_evict_o     = sel_val_i & sel_dit_i;
    rsp_evict_tag_o = sel_tag_i;
    // Flush clears the named word
    wb_en           = 1'b1;
    ram_wword_o     = '0;
    if (is_lookup) begin
      ram_wword_o[TagWidth-1:0]         = tag_q;
      ram_wword_o[TagWidth + TW_VAL_BIT] = 1'b1;
      if (any_hit) begin
        sel_way_o       = hit_i;
        rsp_way_o       = hit_i;
        rsp_hit_o       = 1'b1;
        rsp_evict_o     = 1'b0;
        rsp_evict_tag_o = '0;
        // Rewrite only to turn a clean line dirty
        wb_en           = dirty_q & ~(|(hit_i & tw_dit_i));
        ram_wword_o[TagWidth + TW_DIT_BIT] = 1'b1;
      end else begin
        // Miss, the victim's old word decides the eviction
        sel_way_o = miss_way;
        rsp_way_o = miss_way;
        ram_wword_o[TagWidth + TW_DIT_BIT] = dirty_q;
      end
    end
  end

  // Write-back goes out on the push edge, ahead of any later read
  assign wb_mask     = (push & wb_en) ? rsp_way_o : '0;
  assign ram_we_o    = wb_mask;
  assign ram_req_o   = rd_pend_q | (|wb_mask);
  assign ram_index_o = index_q;

  // Every lookup result marks its way as most recently used
  assign plru_update_o = push & is_lookup;
  assign plru_index_o  = index_q;
  assign plru_way_o    = rsp_way_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      rd_pend_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= req_known;
      end else if (push) begin
        busy_q <= 1'b0;
      end
      // Read is issued in the cycle after acceptance
      rd_pend_q <= accept & req_known;
      // Remember the read strobe while the response register is full
      rvalid_q  <= ~push & (rvalid_q | ram_rvalid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_q  <= req_mode_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      way_q   <= req_way_i;
    end
  end

endmodule

// File: tag_store/llc_tag_store.sv
// Top level of the LLC tag store, connects controller, tag RAM, matcher, PLRU and response register
`timescale 1ns/1ns

module llc_tag_store import llc_geom_pkg::*, llc_op_pkg::*; #(
  parameter int unsigned NumLines = DEF_NUM_LINES,
  parameter int unsigned TagWidth = DEF_TAG_WIDTH,
  localparam int unsigned IdxWidth = $clog2(NumLines),
  localparam int unsigned WordWidth = TagWidth + TW_FLAG_BITS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request side
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic [MODE_W-1:0]   req_mode_i,
  input  logic [IdxWidth-1:0] req_index_i,
  input  logic [TagWidth-1:0] req_tag_i,
  input  logic                req_dirty_i,
  input  logic [NUM_WAYS-1:0] req_way_i,
  // Locked ways, never picked as a PLRU victim
  input  logic [NUM_WAYS-1:0] total_lock_i,
  // Response side
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic [NUM_WAYS-1:0] res_way_o,
  output logic                res_hit_o,
  output logic                res_evict_o,
  output logic [TagWidth-1:0] res_evict_tag_o
);

  // Tag RAM port
  logic                               ram_req;
  logic [NUM_WAYS-1:0]                ram_we;
  logic [IdxWidth-1:0]                ram_index;
  logic [WordWidth-1:0]               ram_wword;
  logic [NUM_WAYS-1:0][WordWidth-1:0] ram_rword;
  logic                               ram_rvalid;
  // Matcher
  logic [TagWidth-1:0]                cmp_tag;
  logic [NUM_WAYS-1:0]                cmp_way;
  logic [NUM_WAYS-1:0]                sel_way;
  logic [NUM_WAYS-1:0]                hit;
  logic [NUM_WAYS-1:0]                tw_val;
  logic [NUM_WAYS-1:0]                tw_dit;
  logic [TagWidth-1:0]                sel_tag;
  logic                               sel_val;
  logic                               sel_dit;
  // Replacement
  logic                               plru_update;
  logic [IdxWidth-1:0]                plru_index;
  logic [NUM_WAYS-1:0]                plru_way;
  logic [NUM_WAYS-1:0]                victim;
  // Controller to response register
  logic                               rsp_valid;
  logic                               rsp_ready;
  logic [NUM_WAYS-1:0]                rsp_way;
  logic                               rsp_hit;
  logic                               rsp_evict;
  logic [TagWidth-1:0]                rsp_evict_tag;

  llc_tag_ctrl #(
    .NumLines ( NumLines ),
    .TagWidth ( TagWidth )
  ) u_ctrl (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .req_valid_i     ( req_valid_i   ),
    .req_ready_o     ( req_ready_o   ),
    .req_mode_i      ( req_mode_i    ),
    .req_index_i     ( req_index_i   ),
    .req_tag_i       ( req_tag_i     ),
    .req_dirty_i     ( req_dirty_i   ),
    .req_way_i       ( req_way_i     ),
    .ram_req_o       ( ram_req       ),
    .ram_we_o        ( ram_we        ),
    .ram_index_o     ( ram_index     ),
    .ram_wword_o     ( ram_wword     ),
    .ram_rvalid_i    ( ram_rvalid    ),
    .cmp_tag_o       ( cmp_tag       ),
    .cmp_way_o       ( cmp_way       ),
    .sel_way_o       ( sel_way       ),
    .hit_i           ( hit           ),
    .tw_val_i        ( tw_val        ),
    .tw_dit_i        ( tw_dit        ),
    .sel_tag_i       ( sel_tag       ),
    .sel_val_i       ( sel_val       ),
    .sel_dit_i       ( sel_dit       ),
    .plru_update_o   ( plru_update   ),
    .plru_index_o    ( plru_index    ),
    .plru_way_o      ( plru_way      ),
    .victim_i        ( victim        ),
    .rsp_valid_o     ( rsp_valid     ),
    .rsp_ready_i     ( rsp_ready     ),
    .rsp_way_o       ( rsp_way       ),
    .rsp_hit_o       ( rsp_hit       ),
    .rsp_evict_o     ( rsp_evict     ),
    .rsp_evict_tag_o ( rsp_evict_tag )
  );

  llc_tag_ram #(
    .NumLines ( NumLines ),
    .TagWidth ( TagWidth )
  ) u_ram (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .ram_req_i ( ram_req    ),
    .ram_we_i  ( ram_we     ),
    .index_i   ( ram_index  ),
    .wword_i   ( ram_wword  ),
    .rword_o   ( ram_rword  ),
    .rvalid_o  ( ram_rvalid )
  );

  llc_tag_match #(
    .TagWidth ( TagWidth )
  ) u_match (
    .rword_i   ( ram_rword ),
    .cmp_tag_i ( cmp_tag   ),
    .cmp_way_i ( cmp_way   ),
    .sel_way_i ( sel_way   ),
    .hit_o     ( hit       ),
    .tw_val_o  ( tw_val    ),
    .tw_dit_o  ( tw_dit    ),
    .sel_tag_o ( sel_tag   ),
    .sel_val_o ( sel_val   ),
    .sel_dit_o ( sel_dit   )
  );

  // Victim choice only looks at the ways the requester enabled
  llc_plru #(
    .NumLines ( NumLines )
  ) u_plru (
    .clk_i    ( clk_i        ),
    .rst_n_i  ( rst_n_i      ),
    .update_i ( plru_update  ),
    .index_i  ( plru_index   ),
    .way_i    ( plru_way     ),
    .lock_i   ( total_lock_i ),
    .enable_i ( cmp_way      ),
    .victim_o ( victim       )
  );

  llc_resp_reg #(
    .TagWidth ( TagWidth )
  ) u_resp (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .valid_i     ( rsp_valid       ),
    .ready_o     ( rsp_ready       ),
    .way_i       ( rsp_way         ),
    .hit_i       ( rsp_hit         ),
    .evict_i     ( rsp_evict       ),
    .evict_tag_i ( rsp_evict_tag   ),
    .valid_o     ( res_valid_o     ),
    .ready_i     ( res_ready_i     ),
    .way_o       ( res_way_o       ),
    .hit_o       ( res_hit_o       ),
    .evict_o     ( res_evict_o     ),
    .evict_tag_o ( res_evict_tag_o )
  );

endmodule

// File: verif/llc_tag_store_tb.sv
// Self-checking testbench for the LLC tag store that runs a request table and then random lookups
`timescale 1ns/1ns

module llc_tag_store_tb import llc_geom_pkg::*, llc_op_pkg::*; ();

  localparam int LINES       = DEF_NUM_LINES;
  localparam int TAG_W       = DEF_TAG_WIDTH;
  localparam int IDX_W       = $clog2(LINES);
  localparam int WAYS        = NUM_WAYS;
  localparam int CLK_PERIOD  = 40;
  localparam int N_TBL       = 24;
  localparam int N_RAND      = 40;
  localparam int N_ENT       = N_TBL + N_RAND;
  localparam int WATCHDOG_NS = N_ENT * 20 * CLK_PERIOD;

  logic              clk_i;
  logic              rst_n_i;
  logic              req_valid_i;
  logic              req_ready_o;
  logic [MODE_W-1:0] req_mode_i;
  logic [IDX_W-1:0]  req_index_i;
  logic [TAG_W-1:0]  req_tag_i;
  logic              req_dirty_i;
  logic [WAYS-1:0]   req_way_i;
  logic [WAYS-1:0]   total_lock_i;
  logic              res_valid_o;
  logic              res_ready_i;
  logic [WAYS-1:0]   res_way_o;
  logic              res_hit_o;
  logic              res_evict_o;
  logic [TAG_W-1:0]  res_evict_tag_o;

  // Request entries with the table first and random lookups after it
  logic [MODE_W-1:0] e_mode [N_ENT];
  logic [IDX_W-1:0]  e_idx [N_ENT];
  logic [TAG_W-1:0]  e_tag [N_ENT];
  logic              e_dirty [N_ENT];
  logic [WAYS-1:0]   e_way [N_ENT];
  logic [WAYS-1:0]   e_lock [N_ENT];
  int                e_hold [N_ENT];
  // Expected hit and evict given by the table for table entries only
  logic              e_chk [N_ENT];
  logic              e_xhit [N_ENT];
  logic              e_xev [N_ENT];
  // Model results filled in when a request is accepted
  logic [WAYS-1:0]   x_way [N_ENT];
  logic              x_hit [N_ENT];
  logic              x_ev [N_ENT];
  logic [TAG_W-1:0]  x_tag [N_ENT];
  int                acc_cyc [N_ENT];

  // Reference tag store and tree bits per set
  logic [WAYS-1:0]   m_val [LINES];
  logic [WAYS-1:0]   m_dit [LINES];
  logic [TAG_W-1:0]  m_tag [LINES][WAYS];
  logic [2:0]        m_tree [LINES];

  integer seed = 32'h3f9d8089;
  int     n_tbl = 0;
  int     cyc = 0;
  int     acc_count = 0;
  int     err_count = 0;
  int     pass_count = 0;
  int     fail_count = 0;

  llc_tag_store #(
    .NumLines ( LINES ),
    .TagWidth ( TAG_W )
  ) UUT (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .req_mode_i      ( req_mode_i      ),
    .req_index_i     ( req_index_i     ),
    .req_tag_i       ( req_tag_i       ),
    .req_dirty_i     ( req_dirty_i     ),
    .req_way_i       ( req_way_i       ),
    .total_lock_i    ( total_lock_i    ),
    .res_valid_o     ( res_valid_o     ),
    .res_ready_i     ( res_ready_i     ),
    .res_way_o       ( res_way_o       ),
    .res_hit_o       ( res_hit_o       ),
    .res_evict_o     ( res_evict_o     ),
    .res_evict_tag_o ( res_evict_tag_o )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Cycle count and accepted-request count sampled before the edge
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (rst_n_i && req_valid_i && req_ready_o) begin
      acc_count <= acc_count + 1;
    end
  end

  function automatic int lowest_index(input logic [WAYS-1:0] mask);
    int i;
    int idx;
    idx = -1;
    for (i = WAYS - 1; i >= 0; i--) begin
      if (mask[i]) idx = i;
    end
    return idx;
  endfunction

  // Tree walk with a fall back to the lowest enabled unlocked way when the tree hits a blocked one
  function automatic int plru_pick(input logic [2:0] bits, input logic [WAYS-1:0] en,
                                   input logic [WAYS-1:0] lock);
    int w;
    logic [WAYS-1:0] ok;
    ok = en & ~lock;
    if (bits[0]) w = bits[2] ? 3 : 2;
    else w = bits[1] ? 1 : 0;
    if (!ok[w]) w = lowest_index(ok);
    return w;
  endfunction

  // Tree bits point away from the accessed way
  task automatic touch_way(input int s, input int w);
    if (w < 2) begin
      m_tree[s][0] = 1'b1;
      m_tree[s][1] = (w == 0);
    end else begin
      m_tree[s][0] = 1'b0;
      m_tree[s][2] = (w == 2);
    end
  endtask

  task automatic predict(input int k);
    int s;
    int w;
    int i;
    logic [WAYS-1:0] hitv;
    s = int'(e_idx[k]);
    x_hit[k] = 1'b0;
    if (e_mode[k] == MODE_FLUSH) begin
      w = lowest_index(e_way[k]);
      x_ev[k]  = m_val[s][w] & m_dit[s][w];
      x_tag[k] = m_tag[s][w];
      m_val[s][w] = 1'b0;
      m_dit[s][w] = 1'b0;
      m_tag[s][w] = '0;
    end else begin
      for (i = 0; i < WAYS; i++) begin
        hitv[i] = e_way[k][i] & m_val[s][i] & (m_tag[s][i] == e_tag[k]);
      end
      if (|hitv) begin
        w = lowest_index(hitv);
        x_hit[k] = 1'b1;
        x_ev[k]  = 1'b0;
        if (e_dirty[k]) m_dit[s][w] = 1'b1;
      end else begin
        // Empty enabled way first and otherwise the replacement victim
        w = lowest_index(e_way[k] & ~m_val[s]);
        if (w < 0) w = plru_pick(m_tree[s], e_way[k], e_lock[k]);
        x_ev[k]  = m_val[s][w] & m_dit[s][w];
        x_tag[k] = m_tag[s][w];
        m_val[s][w] = 1'b1;
        m_dit[s][w] = e_dirty[k];
        m_tag[s][w] = e_tag[k];
      end
      touch_way(s, w);
    end
    x_way[k] = 4'b0001 << w;
  endtask

  task automatic add_entry(input logic [MODE_W-1:0] mode, input logic [IDX_W-1:0] idx,
                           input logic [TAG_W-1:0] tag, input logic dirty,
                           input logic [WAYS-1:0] way, input logic [WAYS-1:0] lock,
                           input int hold, input logic xhit, input logic xev);
    e_mode[n_tbl]  = mode;
    e_idx[n_tbl]   = idx;
    e_tag[n_tbl]   = tag;
    e_dirty[n_tbl] = dirty;
    e_way[n_tbl]   = way;
    e_lock[n_tbl]  = lock;
    e_hold[n_tbl]  = hold;
    e_chk[n_tbl]   = 1'b1;
    e_xhit[n_tbl]  = xhit;
    e_xev[n_tbl]   = xev;
    n_tbl++;
  endtask

  // mode, set, tag, dirty, way mask, lock mask, ready-low cycles, hit, evict
  task automatic load_table();
    // Empty set misses into the lowest enabled way and a repeat hits
    add_entry(MODE_LOOKUP, 4'd1, 12'h100, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd1, 12'h100, 1'b0, 4'hF, 4'h0, 0, 1'b1, 1'b0);
    add_entry(MODE_LOOKUP, 4'd1, 12'h101, 1'b0, 4'hC, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd1, 12'h101, 1'b0, 4'hF, 4'h0, 0, 1'b1, 1'b0);
    // Dirty hit on a clean line and then a miss that evicts it
    add_entry(MODE_LOOKUP, 4'd2, 12'h200, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd2, 12'h200, 1'b1, 4'hF, 4'h0, 0, 1'b1, 1'b0);
    add_entry(MODE_LOOKUP, 4'd2, 12'h201, 1'b0, 4'h1, 4'h0, 0, 1'b0, 1'b1);
    // Fill a set and then replace with history, locks and masks
    add_entry(MODE_LOOKUP, 4'd3, 12'h300, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd3, 12'h301, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd3, 12'h302, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd3, 12'h303, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd3, 12'h301, 1'b0, 4'hF, 4'h0, 0, 1'b1, 1'b0);
    add_entry(MODE_LOOKUP, 4'd3, 12'h310, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    // Tree points at locked way 0 here
    add_entry(MODE_LOOKUP, 4'd3, 12'h311, 1'b0, 4'hF, 4'h1, 0, 1'b0, 1'b0);
    // Tree points at way 3 which is not enabled, way 0 is locked
    add_entry(MODE_LOOKUP, 4'd3, 12'h312, 1'b0, 4'h7, 4'h1, 0, 1'b0, 1'b0);
    // Flush of a dirty way followed by a missing lookup and a clean second flush
    add_entry(MODE_LOOKUP, 4'd4, 12'h400, 1'b1, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_FLUSH,  4'd4, 12'h000, 1'b0, 4'h1, 4'h0, 0, 1'b0, 1'b1);
    add_entry(MODE_LOOKUP, 4'd4, 12'h400, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
    add_entry(MODE_FLUSH,  4'd4, 12'h000, 1'b0, 4'h1, 4'h0, 0, 1'b0, 1'b0);
    // Back-pressure on the response side
    add_entry(MODE_LOOKUP, 4'd5, 12'h500, 1'b1, 4'hF, 4'h0, 6, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd5, 12'h501, 1'b0, 4'hF, 4'h0, 3, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd5, 12'h500, 1'b0, 4'hF, 4'h0, 0, 1'b1, 1'b0);
    add_entry(MODE_FLUSH,  4'd5, 12'h000, 1'b0, 4'h2, 4'h0, 2, 1'b0, 1'b0);
    add_entry(MODE_LOOKUP, 4'd5, 12'h502, 1'b0, 4'hF, 4'h0, 0, 1'b0, 1'b0);
  endtask

  // Waits for an idle controller, presents the request and records the accept
  task automatic issue_request(input int k);
    while (req_ready_o !== 1'b1) begin
      @(posedge clk_i);
      #5;
    end
    req_valid_i  = 1'b1;
    req_mode_i   = e_mode[k];
    req_index_i  = e_idx[k];
    req_tag_i    = e_tag[k];
    req_dirty_i  = e_dirty[k];
    req_way_i    = e_way[k];
    total_lock_i = e_lock[k];
    @(posedge clk_i);
    #5;
    req_valid_i = 1'b0;
    acc_cyc[k]  = cyc;
    predict(k);
  endtask

  task automatic report_mismatch(input int k, input string what, input logic [31:0] expv,
                                 input logic [31:0] gotv);
    err_count++;
    $display("FAILED %0t: test %0d %s expected %0h got %0h", $time, k, what, expv, gotv);
  endtask

  task automatic collect_response(input int k);
    int h;
    int errs_before;
    logic [WAYS-1:0]  way_s;
    logic             hit_s;
    logic             ev_s;
    logic [TAG_W-1:0] tag_s;
    errs_before = err_count;
    res_ready_i = (e_hold[k] == 0);
    while (res_valid_o !== 1'b1) begin
      @(posedge clk_i);
      #5;
    end
    way_s = res_way_o;
    hit_s = res_hit_o;
    ev_s  = res_evict_o;
    tag_s = res_evict_tag_o;
    if (res_way_o !== x_way[k]) report_mismatch(k, "way", 32'(x_way[k]), 32'(res_way_o));
    if (res_hit_o !== x_hit[k]) report_mismatch(k, "hit", 32'(x_hit[k]), 32'(res_hit_o));
    if (res_evict_o !== x_ev[k]) report_mismatch(k, "evict", 32'(x_ev[k]), 32'(res_evict_o));
    if (x_ev[k] && res_evict_tag_o !== x_tag[k]) begin
      report_mismatch(k, "evict tag", 32'(x_tag[k]), 32'(res_evict_tag_o));
    end
    if (e_chk[k] && res_hit_o !== e_xhit[k]) begin
      report_mismatch(k, "table hit", 32'(e_xhit[k]), 32'(res_hit_o));
    end
    if (e_chk[k] && res_evict_o !== e_xev[k]) begin
      report_mismatch(k, "table evict", 32'(e_xev[k]), 32'(res_evict_o));
    end
    // Latency only holds when the response register was free all along
    if (e_hold[k] == 0 && (k == 0 || e_hold[k-1] == 0)) begin
      if (cyc - acc_cyc[k] != 2) report_mismatch(k, "latency", 32'd2, 32'(cyc - acc_cyc[k]));
    end
    for (h = 0; h < e_hold[k]; h++) begin
      @(posedge clk_i);
      #5;
      if (res_valid_o !== 1'b1 || res_way_o !== way_s || res_hit_o !== hit_s ||
          res_evict_o !== ev_s || res_evict_tag_o !== tag_s) begin
        err_count++;
        $display("FAILED %0t: test %0d response changed while res_ready_i was low", $time, k);
      end
      if (acc_count - k > 2) begin
        err_count++;
        $display("Test %0d: more than two requests taken while the response stalled", k);
      end
    end
    res_ready_i = 1'b1;
    @(posedge clk_i);
    #5;
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %0d passed", k);
    end else begin
      fail_count++;
      $display("test %0d failed", k);
    end
  endtask

  initial begin
    int k;
    int s;
    int w;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_mode_i   = '0;
    req_index_i  = '0;
    req_tag_i    = '0;
    req_dirty_i  = 1'b0;
    req_way_i    = '0;
    total_lock_i = '0;
    res_ready_i  = 1'b1;
    for (s = 0; s < LINES; s++) begin
      m_val[s]  = '0;
      m_dit[s]  = '0;
      m_tree[s] = 3'b000;
      for (w = 0; w < WAYS; w++) m_tag[s][w] = '0;
    end
    load_table();
    // Random lookups with all ways enabled on sets the table leaves alone
    for (k = N_TBL; k < N_ENT; k++) begin
      e_mode[k]  = MODE_LOOKUP;
      e_idx[k]   = IDX_W'(8 + ($random(seed) & 3));
      e_tag[k]   = TAG_W'(32'h800 + ($random(seed) & 7));
      e_dirty[k] = (($random(seed) & 1) != 0);
      e_way[k]   = 4'hF;
      e_lock[k]  = 4'($random(seed));
      // Keep at least one way free of the lock
      if (e_lock[k] == 4'hF) e_lock[k] = 4'h7;
      e_hold[k]  = 0;
      e_chk[k]   = 1'b0;
      e_xhit[k]  = 1'b0;
      e_xev[k]   = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    fork
      begin
        for (int t = 0; t < N_TBL; t++) issue_request(t);
        for (int r = N_TBL; r < N_ENT; r++) issue_request(r);
      end
      begin
        for (int c = 0; c < N_ENT; c++) collect_response(c);
      end
    join
    $display("%0d tests passed, %0d tests failed, %0d errors", pass_count, fail_count,
             err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Ends the run after twenty cycles per request
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all responses arrived");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: llc_tag_store.f
common/llc_geom_pkg.sv
common/llc_op_pkg.sv
logic/llc_tag_ram.sv
logic/llc_tag_match.sv
logic/llc_plru.sv
logic/llc_resp_reg.sv
tag_store/llc_tag_ctrl.sv
tag_store/llc_tag_store.sv
verif/llc_tag_store_tb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= llc_tag_store_tb
RTL_TOP    ?= llc_tag_store
FILELIST   ?= llc_tag_store.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= SOME TESTS FAILED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
